// ==== hw/enq_pkg.sv ====
package enq_pkg;

    ////////////////////
    // queue geometry
    ////////////////////

    // four network ports plus the cpu queue
    localparam int queue_num    = 5;
    localparam int cpu_queue    = 4;

    ////////////////////
    // metadata layout
    ////////////////////

    localparam int tuser_w      = 128;
    localparam int src_pos      = 16;
    localparam int dst_pos      = 24;
    localparam int drop_pos     = 32;
    // src and dst fields are one-hot {dma, nf3, dma, nf2, dma, nf1, dma, nf0}
    localparam int port_field_w = 8;

    // cpu read port, addr[7:4] is source and addr[3:0] is destination
    localparam int axi_addr_w   = 8;
    localparam int axi_data_w   = 32;

    typedef logic [queue_num-1:0]  port_mask_t;
    typedef logic [2:0]            src_idx_t;
    typedef logic [axi_data_w-1:0] drop_count_t;
    typedef logic [tuser_w-1:0]    tuser_t;

    typedef enum logic [1:0]
    {
        idle,
        enq_sop,
        enq_remain,
        drop_pkt
    } enq_state_t;

endpackage

// ==== hw/pkt_class_if.sv ====
`timescale 1ns/1ns

interface pkt_class_if
    import enq_pkg::*;
();

    // destination queues named by the metadata
    port_mask_t dst_mask;
    // destinations that still have room
    port_mask_t eligible;
    src_idx_t   src_idx;
    // packet must be dropped
    logic       reject;

    modport producer
    (
        output dst_mask,
        output eligible,
        output src_idx,
        output reject
    );

    modport consumer
    (
        input dst_mask,
        input eligible,
        input src_idx,
        input reject
    );

endinterface

// ==== hw/meta_classifier.sv ====
`timescale 1ns/1ns

module meta_classifier
    import enq_pkg::*;
(
    input  tuser_t           s_axis_tuser,
    input  logic             s_axis_tpifo_valid,
    input  port_mask_t       s_axis_buffer_almost_full,
    input  port_mask_t       s_axis_pifo_full,
    pkt_class_if.producer    cls
);

    logic [port_field_w-1:0] src_field;
    logic [port_field_w-1:0] dst_field;
    port_mask_t              dst_mask_c;
    port_mask_t              eligible_c;

    assign src_field = s_axis_tuser[src_pos +: port_field_w];
    assign dst_field = s_axis_tuser[dst_pos +: port_field_w];

    // even bits are the network ports, every odd bit is a dma lane
    always_comb
    begin
        dst_mask_c = '0;
        for (int q = 0; q < cpu_queue; q++)
        begin
            dst_mask_c[q] = dst_field[2*q];
            dst_mask_c[cpu_queue] = dst_mask_c[cpu_queue] | dst_field[2*q+1];
        end
    end

    // one-hot source to index, anything unknown counts as cpu
    always_comb
    begin
        case (src_field)
            8'h01:   cls.src_idx = src_idx_t'(0);
            8'h04:   cls.src_idx = src_idx_t'(1);
            8'h10:   cls.src_idx = src_idx_t'(2);
            8'h40:   cls.src_idx = src_idx_t'(3);
            default: cls.src_idx = src_idx_t'(cpu_queue);
        endcase
    end

    // drop the queues that cannot take another packet
    assign eligible_c = dst_mask_c & ~s_axis_buffer_almost_full & ~s_axis_pifo_full;

    assign cls.dst_mask = dst_mask_c;
    assign cls.eligible = eligible_c;
    assign cls.reject   = s_axis_tuser[drop_pos] | ~s_axis_tpifo_valid | ~(|eligible_c);

endmodule

// ==== hw/enqueue_fsm.sv ====
`timescale 1ns/1ns

module enqueue_fsm
    import enq_pkg::*;
(
    input  logic             axis_aclk,
    input  logic             axis_resetn,
    input  logic             s_axis_tvalid,
    input  logic             s_axis_tlast,
    pkt_class_if.consumer    cls,
    output logic             s_axis_tready,
    output port_mask_t       pifo_in_en,
    output port_mask_t       buffer_wr_en,
    output logic             drop_strobe
);

    enq_state_t state;
    enq_state_t state_next;
    logic       beat;

    ////////////////////
    // handshake
    ////////////////////

    // the first beat is only inspected in idle, it moves in the next state
    assign s_axis_tready = (state != idle);
    assign beat          = s_axis_tvalid & s_axis_tready;

    // one pulse per dropped packet, taken from the idle decision
    assign drop_strobe   = (state == idle) & s_axis_tvalid & cls.reject;

    ////////////////////
    // next state
    ////////////////////

    always_comb
    begin
        state_next = state;
        case (state)
            idle:
                if (s_axis_tvalid)
                    state_next = cls.reject ? drop_pkt : enq_sop;
            enq_sop:
                if (beat)
                    state_next = enq_remain;
            enq_remain,
            drop_pkt:
                if (beat && s_axis_tlast)
                    state_next = idle;
            default:
                state_next = idle;
        endcase
    end

    ////////////////////
    // state and enables
    ////////////////////

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            state        <= idle;
            pifo_in_en   <= '0;
            buffer_wr_en <= '0;
        end
        else
        begin
            state      <= state_next;
            // insert is a single cycle pulse
            pifo_in_en <= '0;
            if (state == enq_sop && beat)
            begin
                pifo_in_en   <= cls.eligible;
                buffer_wr_en <= cls.eligible;
            end
            else if (state == enq_remain && beat && s_axis_tlast)
                buffer_wr_en <= '0;
        end
    end

endmodule

// ==== hw/drop_counter_bank.sv ====
`timescale 1ns/1ns

module drop_counter_bank
    import enq_pkg::*;
(
    input  logic                  axis_aclk,
    input  logic                  axis_resetn,
    input  logic                  drop_strobe,
    pkt_class_if.consumer         cls,
    input  logic [axi_addr_w-1:0] s_axi_addr,
    input  logic                  s_axi_req_valid,
    output drop_count_t           m_axi_data,
    output logic                  m_axi_resp_valid
);

    // indexed [destination queue][source port]
    drop_count_t               drop_cnt [queue_num][queue_num];

    logic [axi_addr_w/2-1:0]   rd_src;
    logic [axi_addr_w/2-1:0]   rd_dst;
    logic [axi_addr_w/2-1:0]   rd_dst_sel;
    drop_count_t               rd_word;

    ////////////////////
    // counter matrix
    ////////////////////

    // a multicast drop bumps every destination it named
    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            for (int d = 0; d < queue_num; d++)
                for (int s = 0; s < queue_num; s++)
                    drop_cnt[d][s] <= '0;
        end
        else if (drop_strobe)
        begin
            for (int d = 0; d < queue_num; d++)
                for (int s = 0; s < queue_num; s++)
                    if (cls.dst_mask[d] && cls.src_idx == src_idx_t'(s))
                        drop_cnt[d][s] <= drop_cnt[d][s] + 1'b1;
        end
    end

    ////////////////////
    // cpu read port
    ////////////////////

    assign rd_src     = s_axi_addr[axi_addr_w-1:axi_addr_w/2];
    assign rd_dst     = s_axi_addr[axi_addr_w/2-1:0];
    // high destination numbers alias onto the cpu queue
    assign rd_dst_sel = (rd_dst >= cpu_queue) ? (axi_addr_w/2)'(cpu_queue) : rd_dst;

    // unknown sources match nothing and read as zero
    always_comb
    begin
        rd_word = '0;
        for (int d = 0; d < queue_num; d++)
            for (int s = 0; s < queue_num; s++)
                if (rd_dst_sel == d && rd_src == s)
                    rd_word = drop_cnt[d][s];
    end

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            m_axi_data       <= '0;
            m_axi_resp_valid <= 1'b0;
        end
        else
        begin
            m_axi_resp_valid <= s_axi_req_valid;
            if (s_axi_req_valid)
                m_axi_data <= rd_word;
        end
    end

endmodule

// ==== hw/enqueue_agent.sv ====
`timescale 1ns/1ns

module enqueue_agent
    import enq_pkg::*;
(
    input  logic                  axis_aclk,
    input  logic                  axis_resetn,

    // pipeline stream
    input  logic                  s_axis_tvalid,
    output logic                  s_axis_tready,
    input  tuser_t                s_axis_tuser,
    input  logic                  s_axis_tlast,
    input  logic                  s_axis_tpifo_valid,

    // queue status and control
    input  port_mask_t            s_axis_buffer_almost_full,
    input  port_mask_t            s_axis_pifo_full,
    output port_mask_t            m_axis_ctl_pifo_in_en,
    output port_mask_t            m_axis_ctl_buffer_wr_en,

    // cpu drop counter reads
    input  logic [axi_addr_w-1:0] s_axi_addr,
    input  logic                  s_axi_req_valid,
    output drop_count_t           m_axi_data,
    output logic                  m_axi_resp_valid
);

    logic drop_strobe;

    pkt_class_if cls_if ();

    meta_classifier classifier_i
    (
        .s_axis_tuser              (s_axis_tuser),
        .s_axis_tpifo_valid        (s_axis_tpifo_valid),
        .s_axis_buffer_almost_full (s_axis_buffer_almost_full),
        .s_axis_pifo_full          (s_axis_pifo_full),
        .cls                       (cls_if.producer)
    );

    enqueue_fsm fsm_i
    (
        .axis_aclk     (axis_aclk),
        .axis_resetn   (axis_resetn),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tlast  (s_axis_tlast),
        .cls           (cls_if.consumer),
        .s_axis_tready (s_axis_tready),
        .pifo_in_en    (m_axis_ctl_pifo_in_en),
        .buffer_wr_en  (m_axis_ctl_buffer_wr_en),
        .drop_strobe   (drop_strobe)
    );

    drop_counter_bank counters_i
    (
        .axis_aclk        (axis_aclk),
        .axis_resetn      (axis_resetn),
        .drop_strobe      (drop_strobe),
        .cls              (cls_if.consumer),
        .s_axi_addr       (s_axi_addr),
        .s_axi_req_valid  (s_axi_req_valid),
        .m_axi_data       (m_axi_data),
        .m_axi_resp_valid (m_axi_resp_valid)
    );

endmodule

// ==== test/enqueue_agent_asserts.sv ====
`timescale 1ns/1ns

module enqueue_agent_asserts
    import enq_pkg::*;
(
    input  logic       axis_aclk,
    input  logic       axis_resetn,
    input  enq_state_t state,
    input  port_mask_t pifo_in_en,
    input  port_mask_t buffer_wr_en
);

    // insert is a single cycle pulse per packet
    assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
        (|pifo_in_en) |=> !(|pifo_in_en))
    else $error("pifo_in_en high on two consecutive cycles");

    // a dropped packet is drained without touching any queue
    assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
        (state == drop_pkt) |-> (pifo_in_en == '0 && buffer_wr_en == '0))
    else $error("enable raised while dropping a packet");

    assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
        (state == idle) |-> (buffer_wr_en == '0))
    else $error("buffer_wr_en not zero while idle");

    // write mask holds through the body of the packet
    assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
        (state == enq_remain) |=> (state == idle) || $stable(buffer_wr_en))
    else $error("buffer_wr_en changed in the middle of a packet");

endmodule

bind enqueue_fsm enqueue_agent_asserts fsm_asserts_i
(
    .axis_aclk     (axis_aclk),
    .axis_resetn   (axis_resetn),
    .state         (state),
    .pifo_in_en    (pifo_in_en),
    .buffer_wr_en  (buffer_wr_en)
);

// ==== test/enqueue_agent_tb.sv ====
`timescale 1ns/1ns

module enqueue_agent_tb;
    import enq_pkg::*;

    localparam int wait_limit = 50;

    logic                  axis_aclk;
    logic                  axis_resetn;
    logic                  s_axis_tvalid;
    logic                  s_axis_tready;
    tuser_t                s_axis_tuser;
    logic                  s_axis_tlast;
    logic                  s_axis_tpifo_valid;
    port_mask_t            s_axis_buffer_almost_full;
    port_mask_t            s_axis_pifo_full;
    port_mask_t            m_axis_ctl_pifo_in_en;
    port_mask_t            m_axis_ctl_buffer_wr_en;
    logic [axi_addr_w-1:0] s_axi_addr;
    logic                  s_axi_req_valid;
    drop_count_t           m_axi_data;
    logic                  m_axi_resp_valid;

    integer seed = 32'h579bb731;

    enqueue_agent dut_i (.*);

    initial
    begin
        axis_aclk = 1'b0;
        forever #5 axis_aclk = ~axis_aclk;
    end

    ////////////////////
    // checks
    ////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_mask(input port_mask_t got, input port_mask_t exp, input string what);
        if (got !== exp)
            abort_run($sformatf("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_count(input drop_count_t got, input drop_count_t exp, input string what);
        if (got !== exp)
            abort_run($sformatf("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp));
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp)
            abort_run($sformatf("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp));
    endtask

    ////////////////////
    // packet and read drivers
    ////////////////////

    task automatic send_packet(input logic [7:0] src, input logic [7:0] dst, input logic drop,
                               input logic pv, input int beats, input port_mask_t af,
                               input port_mask_t pf, input port_mask_t exp, input int gaps);
        tuser_t     tu;
        int         sent;
        int         gaps_left;
        int         stall;
        logic       xfer;
        port_mask_t exp_pifo;
        port_mask_t exp_wr;

        // unused metadata fields get random filler
        tu = {$random(seed), $random(seed), $random(seed), $random(seed)};
        tu[src_pos +: port_field_w] = src;
        tu[dst_pos +: port_field_w] = dst;
        tu[drop_pos] = drop;
        sent = 0;
        gaps_left = gaps;
        stall = 0;

        @(negedge axis_aclk);
        s_axis_tuser = tu;
        s_axis_tpifo_valid = pv;
        s_axis_buffer_almost_full = af;
        s_axis_pifo_full = pf;
        s_axis_tvalid = 1'b1;
        s_axis_tlast = (beats == 1);
        check_level(s_axis_tready, 1'b0, "tready before the first beat");
        while (sent < beats)
        begin
            // tready only changes on the rising edge, so this is the handshake seen there
            xfer = s_axis_tvalid & s_axis_tready;
            @(negedge axis_aclk);
            if (xfer)
            begin
                sent++;
                stall = 0;
            end
            else
            begin
                stall++;
                if (stall > wait_limit)
                    abort_run("timed out waiting for tready during a packet");
            end
            exp_pifo = (xfer && sent == 1) ? exp : '0;
            exp_wr = (sent >= 1 && sent < beats) ? exp : '0;
            check_mask(m_axis_ctl_pifo_in_en, exp_pifo, "pifo_in_en");
            check_mask(m_axis_ctl_buffer_wr_en, exp_wr, "buffer_wr_en");
            check_level(s_axis_tready, sent < beats, "tready");
            // next beat, with the idle gaps placed just before the last one
            if (sent == beats || (sent == beats - 1 && gaps_left > 0))
            begin
                s_axis_tvalid = 1'b0;
                s_axis_tlast = 1'b0;
                if (sent < beats)
                    gaps_left--;
            end
            else
            begin
                s_axis_tvalid = 1'b1;
                s_axis_tlast = (sent == beats - 1);
            end
        end
    endtask

    task automatic read_counter(input logic [axi_addr_w-1:0] addr, input drop_count_t exp);
        int waited;

        waited = 0;
        @(negedge axis_aclk);
        s_axi_addr = addr;
        s_axi_req_valid = 1'b1;
        @(negedge axis_aclk);
        s_axi_req_valid = 1'b0;
        // the response must carry the address of the request cycle
        s_axi_addr = ~addr;
        while (!m_axi_resp_valid)
        begin
            if (waited >= wait_limit)
                abort_run("timed out waiting for m_axi_resp_valid");
            @(negedge axis_aclk);
            waited++;
        end
        if (waited != 0)
            abort_run($sformatf("MISMATCH at %0t: read response %0d cycles late", $time, waited));
        check_count(m_axi_data, exp, $sformatf("drop count at address %h", addr));
        @(negedge axis_aclk);
        check_level(m_axi_resp_valid, 1'b0, "resp_valid after one cycle");
    endtask

    task automatic play_commands();
        int          fd;
        int          n;
        int          done;
        string       line;
        logic [7:0]  src;
        logic [7:0]  dst;
        logic        drop;
        logic        pv;
        int          beats;
        port_mask_t  af;
        port_mask_t  pf;
        port_mask_t  exp;
        int          gaps;
        logic [7:0]  addr;
        int          count;

        done = 0;
        fd = $fopen("test/enqueue_stimulus.txt", "r");
        if (fd == 0)
            abort_run("could not open test/enqueue_stimulus.txt");
        while (!$feof(fd))
        begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) == "P")
            begin
                n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %d %h %h %h %d",
                            src, dst, drop, pv, beats, af, pf, exp, gaps);
                if (n != 9 || beats < 2)
                    abort_run({"bad packet line in stimulus file: ", line});
                send_packet(src, dst, drop, pv, beats, af, pf, exp, gaps);
                done++;
            end
            else if (n > 1 && line.getc(0) == "R")
            begin
                n = $sscanf(line.substr(1, line.len() - 1), "%h %d", addr, count);
                if (n != 2)
                    abort_run({"bad read line in stimulus file: ", line});
                read_counter(addr, drop_count_t'(count));
                done++;
            end
        end
        $fclose(fd);
        if (done == 0)
            abort_run("stimulus file held no commands");
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial
    begin
        axis_resetn = 1'b0;
        s_axis_tvalid = 1'b0;
        s_axis_tuser = '0;
        s_axis_tlast = 1'b0;
        s_axis_tpifo_valid = 1'b0;
        s_axis_buffer_almost_full = '0;
        s_axis_pifo_full = '0;
        s_axi_addr = '0;
        s_axi_req_valid = 1'b0;
        repeat (8) @(posedge axis_aclk);
        @(negedge axis_aclk);
        axis_resetn = 1'b1;
        @(negedge axis_aclk);
        check_level(s_axis_tready, 1'b0, "tready after reset");
        check_mask(m_axis_ctl_pifo_in_en, '0, "pifo_in_en after reset");
        check_mask(m_axis_ctl_buffer_wr_en, '0, "buffer_wr_en after reset");
        check_level(m_axi_resp_valid, 1'b0, "resp_valid after reset");
        check_count(m_axi_data, '0, "read data after reset");
        play_commands();
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== sources.f ====
hw/enq_pkg.sv
hw/pkt_class_if.sv
hw/meta_classifier.sv
hw/enqueue_fsm.sv
hw/drop_counter_bank.sv
hw/enqueue_agent.sv
test/enqueue_agent_asserts.sv
test/enqueue_agent_tb.sv

// ==== Makefile ====
TOP = enqueue_agent_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o sim_tb
	./obj_dir/sim_tb 2>&1 | tee sim.log
	@if grep -q "=== FAIL ===" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" sim.log; then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== test/enqueue_stimulus.txt ====
# P src dst drop pifo_valid beats almost_full pifo_full expected_eligible gaps
# R addr expected_count (addr is {src, dst} in hex, beats, gaps and count decimal)
P 01 04 0 1 3 00 00 02 0
P 04 57 0 1 4 04 01 1a 0
P 10 02 0 1 2 00 10 00 0
P 40 11 1 1 3 00 00 00 0
P 01 01 0 0 2 00 00 00 0
P 01 01 1 1 2 00 00 00 1
P 20 44 0 1 2 02 08 00 0
P 10 50 0 1 5 00 00 0c 3
P 04 08 0 1 2 00 00 10 0
R 24 1
R 30 1
R 32 1
R 00 2
R 41 1
R 43 1
R 27 1
R 52 0
R f0 0
R 01 0
R 13 0
P 40 ff 0 0 2 00 00 00 2
R 30 2
R 31 1
R 34 1
